//--- common/dcache_pkg.sv
package dcache_pkg;

    localparam int NUM_SETS  = 256;
    localparam int NUM_WAYS  = 2;
    localparam int NUM_BANKS = 4;
    localparam int WORD_W    = 32;
    localparam int TAG_W     = 20;
    localparam int INDEX_W   = 8;
    localparam int OFFSET_W  = 4;
    localparam logic [7:0] LFSR_SEED = 8'h01;

    typedef logic [TAG_W-1:0]              tag_t;
    typedef logic [INDEX_W-1:0]            index_t;
    typedef logic [OFFSET_W-1:0]           offset_t;
    typedef logic [$clog2(NUM_BANKS)-1:0]  bank_sel_t;  // word within the line
    typedef logic [WORD_W-1:0]             word_t;
    typedef logic [WORD_W/8-1:0]           wstrb_t;
    typedef logic [NUM_BANKS*WORD_W-1:0]   line_t;
    typedef logic [0:0]                    way_t;
    typedef logic [31:0]                   addr_t;      // byte address

    typedef struct packed {
        logic    op;        // 1 for a store
        tag_t    tag;
        index_t  index;
        offset_t offset;
        wstrb_t  wstrb;
        word_t   wdata;
    } cpu_req_t;

    typedef struct packed {
        tag_t tag;
        logic valid;
    } tagv_t;

    // hit store on its way into a data bank
    typedef struct packed {
        logic      valid;
        way_t      way;
        index_t    index;
        bank_sel_t bank;
        wstrb_t    wstrb;
        word_t     wdata;
    } store_wr_t;

    // one refill beat, tag and state written with the last one
    typedef struct packed {
        logic      valid;
        way_t      way;
        index_t    index;
        bank_sel_t bank;
        word_t     data;
        logic      tag_wr;
        tag_t      tag;
        logic      dirty;
    } refill_wr_t;

    typedef enum logic [2:0] {
        MAIN_IDLE,
        MAIN_LOOKUP,
        MAIN_MISS,
        MAIN_REPLACE,
        MAIN_REFILL
    } main_state_t;

    typedef enum logic {
        SB_IDLE,
        SB_WRITE
    } sb_state_t;

endpackage

//--- cache_arrays/sram_bank.sv
`timescale 1ns/1ps

module sram_bank #(
    parameter int WIDTH   = 32,
    parameter int GROUP_W = 8     // bits per write strobe
) (
    input  logic                clk,
    input  logic                en,
    input  dcache_pkg::wstrb_t  we,
    input  dcache_pkg::index_t  addr,
    input  logic [WIDTH-1:0]    din,
    output logic [WIDTH-1:0]    dout
);

    logic [WIDTH-1:0] mem [dcache_pkg::NUM_SETS];

    always_ff @(posedge clk) begin
        if (en) begin
            if (|we) begin
                for (int g = 0; g < WIDTH / GROUP_W; g++) begin
                    if (we[g]) begin
                        mem[addr][g*GROUP_W +: GROUP_W] <= din[g*GROUP_W +: GROUP_W];
                    end
                end
            end else begin
                dout <= mem[addr];  // holds through a write cycle
            end
        end
    end

endmodule

//--- cache_arrays/cache_arrays.sv
`timescale 1ns/1ps

module cache_arrays (
    input  logic                                          clk,
    input  logic                                          reset,
    input  dcache_pkg::index_t                            rd_index,
    input  dcache_pkg::store_wr_t                         sb_wr,
    input  dcache_pkg::refill_wr_t                        refill_wr,
    input  logic [dcache_pkg::NUM_WAYS-1:0]               dirty_clr_way,
    output dcache_pkg::tagv_t [dcache_pkg::NUM_WAYS-1:0]  tagv_q,
    output dcache_pkg::line_t [dcache_pkg::NUM_WAYS-1:0]  line_q,
    output logic [dcache_pkg::NUM_WAYS-1:0]               dirty_q
);

    logic [dcache_pkg::NUM_WAYS-1:0][dcache_pkg::NUM_SETS-1:0] valid_bits;
    logic [dcache_pkg::NUM_WAYS-1:0][dcache_pkg::NUM_SETS-1:0] dirty_bits;
    dcache_pkg::index_t index_q;    // index behind the bank outputs
    dcache_pkg::word_t  bank_q [dcache_pkg::NUM_WAYS][dcache_pkg::NUM_BANKS];
    dcache_pkg::tag_t   tag_q  [dcache_pkg::NUM_WAYS];

    for (genvar w = 0; w < dcache_pkg::NUM_WAYS; w++) begin : g_way
        for (genvar b = 0; b < dcache_pkg::NUM_BANKS; b++) begin : g_bank
            logic               sb_sel;
            logic               rf_sel;
            dcache_pkg::wstrb_t we;

            assign sb_sel = sb_wr.valid && (sb_wr.way == w) && (sb_wr.bank == b);
            assign rf_sel = refill_wr.valid && (refill_wr.way == w) && (refill_wr.bank == b);
            assign we     = sb_sel ? sb_wr.wstrb : {$bits(dcache_pkg::wstrb_t){rf_sel}};

            sram_bank #(.WIDTH(dcache_pkg::WORD_W), .GROUP_W(8)) u_data (
                .clk  (clk),
                .en   (1'b1),
                .we   (we),
                .addr (sb_sel ? sb_wr.index : rd_index),
                .din  (sb_sel ? sb_wr.wdata : refill_wr.data),
                .dout (bank_q[w][b])
            );
        end

        // refill reads at its own index, so rd_index already points there
        sram_bank #(.WIDTH(dcache_pkg::TAG_W), .GROUP_W(dcache_pkg::TAG_W)) u_tag (
            .clk  (clk),
            .en   (1'b1),
            .we   (dcache_pkg::wstrb_t'(refill_wr.tag_wr && (refill_wr.way == w))),
            .addr (rd_index),
            .din  (refill_wr.tag),
            .dout (tag_q[w])
        );
    end

    always_ff @(posedge clk) begin
        index_q <= rd_index;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else begin
            for (int w = 0; w < dcache_pkg::NUM_WAYS; w++) begin
                if (refill_wr.tag_wr && (refill_wr.way == w)) begin
                    valid_bits[w][refill_wr.index] <= 1'b1;
                    dirty_bits[w][refill_wr.index] <= refill_wr.dirty;
                end else if (sb_wr.valid && (sb_wr.way == w)) begin
                    dirty_bits[w][sb_wr.index] <= 1'b1;
                end else if (dirty_clr_way[w]) begin
                    dirty_bits[w][rd_index] <= 1'b0;    // after write-back
                end
            end
        end
    end

    always_comb begin
        for (int w = 0; w < dcache_pkg::NUM_WAYS; w++) begin
            tagv_q[w].tag   = tag_q[w];
            tagv_q[w].valid = valid_bits[w][index_q];
            // a store landing this cycle already counts as dirty
            dirty_q[w] = dirty_bits[w][index_q] ||
                         (sb_wr.valid && (sb_wr.way == w) && (sb_wr.index == index_q));
            for (int b = 0; b < dcache_pkg::NUM_BANKS; b++) begin
                line_q[w][b*dcache_pkg::WORD_W +: dcache_pkg::WORD_W] = bank_q[w][b];
            end
        end
    end

endmodule

//--- src/store_buffer.sv
`timescale 1ns/1ps

module store_buffer (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  sb_load,
    input  dcache_pkg::store_wr_t sb_entry,
    output dcache_pkg::store_wr_t sb_wr
);

    dcache_pkg::sb_state_t state;
    dcache_pkg::store_wr_t entry_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= dcache_pkg::SB_IDLE;
        end else begin
            case (state)
                dcache_pkg::SB_IDLE: begin
                    if (sb_load) begin
                        state <= dcache_pkg::SB_WRITE;
                    end
                end
                dcache_pkg::SB_WRITE: begin
                    if (!sb_load) begin
                        state <= dcache_pkg::SB_IDLE;   // stays on a back to back reload
                    end
                end
                default: begin
                    state <= dcache_pkg::SB_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (sb_load) begin
            entry_q <= sb_entry;
        end
    end

    // one bank write per loaded entry, also marks the way dirty
    always_comb begin
        sb_wr       = entry_q;
        sb_wr.valid = (state == dcache_pkg::SB_WRITE);
    end

endmodule

//--- cache_ctrl/cache_ctrl.sv
`timescale 1ns/1ps

module cache_ctrl (
    input  logic                                         clk,
    input  logic                                         reset,
    input  logic                                         valid,
    input  dcache_pkg::cpu_req_t                         req,
    output logic                                         addr_ok,
    output logic                                         data_ok,
    output dcache_pkg::word_t                            rdata,
    output logic                                         rd_req,
    output dcache_pkg::addr_t                            rd_addr,
    input  logic                                         rd_rdy,
    input  logic                                         ret_valid,
    input  logic                                         ret_last,
    input  dcache_pkg::word_t                            ret_data,
    output logic                                         wr_req,
    output dcache_pkg::addr_t                            wr_addr,
    output dcache_pkg::line_t                            wr_data,
    input  logic                                         wr_rdy,
    input  dcache_pkg::store_wr_t                        sb_wr,
    output logic                                         sb_load,
    output dcache_pkg::store_wr_t                        sb_entry,
    output dcache_pkg::index_t                           rd_index,
    input  dcache_pkg::tagv_t [dcache_pkg::NUM_WAYS-1:0] tagv_q,
    input  dcache_pkg::line_t [dcache_pkg::NUM_WAYS-1:0] line_q,
    input  logic [dcache_pkg::NUM_WAYS-1:0]              dirty_q,
    output dcache_pkg::refill_wr_t                       refill_wr,
    output logic [dcache_pkg::NUM_WAYS-1:0]              dirty_clr_way
);

    dcache_pkg::main_state_t         state;
    dcache_pkg::cpu_req_t            req_q;
    dcache_pkg::way_t                victim_q;
    dcache_pkg::bank_sel_t           beat_q;    // refill beat counter
    logic                            wb_armed;
    logic [7:0]                      lfsr;

    logic [dcache_pkg::NUM_WAYS-1:0] way_hit;
    logic                            hit;
    dcache_pkg::way_t                hit_way;
    dcache_pkg::way_t                victim_way;
    dcache_pkg::bank_sel_t           req_bank;
    dcache_pkg::bank_sel_t           cur_bank;
    logic                            sb_conflict;
    logic                            raw_conflict;
    dcache_pkg::word_t               merged_word;

    assign req_bank = req.offset[dcache_pkg::OFFSET_W-1:2];   // incoming request
    assign cur_bank = req_q.offset[dcache_pkg::OFFSET_W-1:2]; // request in lookup

    always_comb begin
        for (int w = 0; w < dcache_pkg::NUM_WAYS; w++) begin
            way_hit[w] = tagv_q[w].valid && (tagv_q[w].tag == req_q.tag);
        end
    end

    assign hit     = |way_hit;
    assign hit_way = way_hit[1];

    // an empty way first, otherwise the lfsr picks
    assign victim_way = !tagv_q[0].valid ? 1'b0 : (!tagv_q[1].valid ? 1'b1 : lfsr[7]);

    // pending bank write blocks a read of the same bank
    assign sb_conflict  = sb_wr.valid && (sb_wr.bank == req_bank);
    // store in lookup not yet buffered, a load behind it would read stale data
    assign raw_conflict = req_q.op && !req.op && (cur_bank == req_bank);

    assign addr_ok = !sb_conflict &&
                     ((state == dcache_pkg::MAIN_IDLE) ||
                      ((state == dcache_pkg::MAIN_LOOKUP) && hit && !raw_conflict));

    assign rd_index = addr_ok ? req.index : req_q.index;

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= dcache_pkg::MAIN_IDLE;
            beat_q   <= '0;
            wb_armed <= 1'b0;
        end else begin
            case (state)
                dcache_pkg::MAIN_IDLE: begin
                    if (valid && addr_ok) begin
                        state <= dcache_pkg::MAIN_LOOKUP;
                    end
                end
                dcache_pkg::MAIN_LOOKUP: begin
                    if (valid && addr_ok) begin
                        state <= dcache_pkg::MAIN_LOOKUP;   // next hit back to back
                    end else if (!hit) begin
                        state <= (dirty_q[victim_way] && tagv_q[victim_way].valid) ?
                                 dcache_pkg::MAIN_MISS : dcache_pkg::MAIN_REPLACE;
                    end else begin
                        state <= dcache_pkg::MAIN_IDLE;
                    end
                end
                dcache_pkg::MAIN_MISS: begin
                    wb_armed <= 1'b1;
                    if (wr_req && wr_rdy) begin
                        state    <= dcache_pkg::MAIN_REPLACE;
                        wb_armed <= 1'b0;
                    end
                end
                dcache_pkg::MAIN_REPLACE: begin
                    if (rd_rdy) begin
                        state  <= dcache_pkg::MAIN_REFILL;
                        beat_q <= '0;
                    end
                end
                dcache_pkg::MAIN_REFILL: begin
                    if (ret_valid) begin
                        beat_q <= beat_q + 1'b1;
                        if (ret_last) begin
                            state <= dcache_pkg::MAIN_IDLE;
                        end
                    end
                end
                default: begin
                    state <= dcache_pkg::MAIN_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (valid && addr_ok) begin
            req_q <= req;
        end
        if ((state == dcache_pkg::MAIN_LOOKUP) && !hit) begin
            victim_q <= victim_way;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            lfsr <= dcache_pkg::LFSR_SEED;
        end else begin
            lfsr <= {lfsr[6], lfsr[5] ^ lfsr[7], lfsr[4] ^ lfsr[7], lfsr[3] ^ lfsr[7],
                     lfsr[2:0], lfsr[7]};
        end
    end

    // stores answer in lookup, hit or miss
    assign data_ok = ((state == dcache_pkg::MAIN_LOOKUP) && (hit || req_q.op)) ||
                     ((state == dcache_pkg::MAIN_REFILL) && ret_valid && !req_q.op &&
                      (beat_q == cur_bank));

    assign rdata = (state == dcache_pkg::MAIN_LOOKUP) ?
                   line_q[hit_way][cur_bank*dcache_pkg::WORD_W +: dcache_pkg::WORD_W] :
                   ret_data;

    assign sb_load = (state == dcache_pkg::MAIN_LOOKUP) && hit && req_q.op;

    always_comb begin
        sb_entry.valid = sb_load;
        sb_entry.way   = hit_way;
        sb_entry.index = req_q.index;
        sb_entry.bank  = cur_bank;
        sb_entry.wstrb = req_q.wstrb;
        sb_entry.wdata = req_q.wdata;
    end

    // a store buffer write in lookup may still land in the victim line,
    // the bank re-read settles one cycle into MISS
    assign wr_req  = (state == dcache_pkg::MAIN_MISS) && wb_armed;
    assign wr_addr = {tagv_q[victim_q].tag, req_q.index, {dcache_pkg::OFFSET_W{1'b0}}};
    assign wr_data = line_q[victim_q];

    assign rd_req  = (state == dcache_pkg::MAIN_REPLACE);
    assign rd_addr = {req_q.tag, req_q.index, {dcache_pkg::OFFSET_W{1'b0}}};

    always_comb begin
        for (int w = 0; w < dcache_pkg::NUM_WAYS; w++) begin
            dirty_clr_way[w] = wr_req && wr_rdy && (victim_q == w);  // line now clean
        end
    end

    always_comb begin
        for (int b = 0; b < dcache_pkg::WORD_W / 8; b++) begin
            merged_word[b*8 +: 8] = req_q.wstrb[b] ? req_q.wdata[b*8 +: 8] : ret_data[b*8 +: 8];
        end
    end

    always_comb begin
        refill_wr.valid  = (state == dcache_pkg::MAIN_REFILL) && ret_valid;
        refill_wr.way    = victim_q;
        refill_wr.index  = req_q.index;
        refill_wr.bank   = beat_q;
        refill_wr.data   = (req_q.op && (beat_q == cur_bank)) ? merged_word : ret_data;
        refill_wr.tag_wr = refill_wr.valid && ret_last;
        refill_wr.tag    = req_q.tag;
        refill_wr.dirty  = req_q.op;    // store miss leaves the line dirty
    end

endmodule

//--- src/dcache_top.sv
`timescale 1ns/1ps

module dcache_top (
    input  logic                 clk,
    input  logic                 reset,
    // cpu side
    input  logic                 valid,
    input  dcache_pkg::cpu_req_t req,
    output logic                 addr_ok,
    output logic                 data_ok,
    output dcache_pkg::word_t    rdata,
    // line read
    output logic                 rd_req,
    output dcache_pkg::addr_t    rd_addr,
    input  logic                 rd_rdy,
    input  logic                 ret_valid,
    input  logic                 ret_last,
    input  dcache_pkg::word_t    ret_data,
    // line write
    output logic                 wr_req,
    output dcache_pkg::addr_t    wr_addr,
    output dcache_pkg::line_t    wr_data,
    input  logic                 wr_rdy
);

    dcache_pkg::store_wr_t                       sb_wr;
    dcache_pkg::store_wr_t                       sb_entry;
    logic                                        sb_load;
    dcache_pkg::index_t                          rd_index;
    dcache_pkg::tagv_t [dcache_pkg::NUM_WAYS-1:0] tagv_q;
    dcache_pkg::line_t [dcache_pkg::NUM_WAYS-1:0] line_q;
    logic [dcache_pkg::NUM_WAYS-1:0]             dirty_q;
    dcache_pkg::refill_wr_t                      refill_wr;
    logic [dcache_pkg::NUM_WAYS-1:0]             dirty_clr_way;

    cache_ctrl u_cache_ctrl (
        .clk           (clk),
        .reset         (reset),
        .valid         (valid),
        .req           (req),
        .addr_ok       (addr_ok),
        .data_ok       (data_ok),
        .rdata         (rdata),
        .rd_req        (rd_req),
        .rd_addr       (rd_addr),
        .rd_rdy        (rd_rdy),
        .ret_valid     (ret_valid),
        .ret_last      (ret_last),
        .ret_data      (ret_data),
        .wr_req        (wr_req),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .wr_rdy        (wr_rdy),
        .sb_wr         (sb_wr),
        .sb_load       (sb_load),
        .sb_entry      (sb_entry),
        .rd_index      (rd_index),
        .tagv_q        (tagv_q),
        .line_q        (line_q),
        .dirty_q       (dirty_q),
        .refill_wr     (refill_wr),
        .dirty_clr_way (dirty_clr_way)
    );

    store_buffer u_store_buffer (
        .clk      (clk),
        .reset    (reset),
        .sb_load  (sb_load),
        .sb_entry (sb_entry),
        .sb_wr    (sb_wr)
    );

    cache_arrays u_cache_arrays (
        .clk           (clk),
        .reset         (reset),
        .rd_index      (rd_index),
        .sb_wr         (sb_wr),
        .refill_wr     (refill_wr),
        .dirty_clr_way (dirty_clr_way),
        .tagv_q        (tagv_q),
        .line_q        (line_q),
        .dirty_q       (dirty_q)
    );

endmodule

//--- tb/dcache_checker.sv
`timescale 1ns/1ps

module dcache_checker (
    input logic clk,
    input logic reset,
    input logic rd_req,
    input logic rd_rdy,
    input logic wr_req,
    input logic wr_rdy,
    input logic data_ok
);

    // one memory port busy at a time
    a_one_port: assert property (@(posedge clk) disable iff (reset) !(rd_req && wr_req))
        else $error("rd_req and wr_req are high together");

    a_rd_hold: assert property (@(posedge clk) disable iff (reset) rd_req && !rd_rdy |=> rd_req)
        else $error("rd_req dropped before rd_rdy");

    a_wr_hold: assert property (@(posedge clk) disable iff (reset) wr_req && !wr_rdy |=> wr_req)
        else $error("wr_req dropped before wr_rdy");

    a_quiet_after_reset: assert property (@(posedge clk) reset |=> !data_ok)
        else $error("data_ok is high in the cycle after reset");

endmodule

bind cache_ctrl dcache_checker u_dcache_checker (
    .clk     (clk),
    .reset   (reset),
    .rd_req  (rd_req),
    .rd_rdy  (rd_rdy),
    .wr_req  (wr_req),
    .wr_rdy  (wr_rdy),
    .data_ok (data_ok)
);

//--- tb/tb_dcache.sv
`timescale 1ns/1ps

module tb_dcache;

    localparam int MAX_PATTERNS = 64;

    logic                 clk = 1'b0;
    logic                 reset;
    logic                 valid;
    dcache_pkg::cpu_req_t req;
    logic                 addr_ok, data_ok, rd_req, rd_rdy, ret_valid, ret_last, wr_req, wr_rdy;
    dcache_pkg::word_t    rdata, ret_data;
    dcache_pkg::addr_t    rd_addr, wr_addr;
    dcache_pkg::line_t    wr_data;

    logic [103:0]      patterns [MAX_PATTERNS];   // op, address, wstrb, wdata, expected
    int                npat = 0;
    int                limit = 0;
    int                cyc = 0;
    int                done_count = 0;
    logic [31:0]       rng = 32'hb4ec8ae1;
    dcache_pkg::word_t cpu_mem [dcache_pkg::addr_t];   // what the cpu should see
    dcache_pkg::word_t mem_img [dcache_pkg::addr_t];   // backing memory
    bit                dirty_lines [dcache_pkg::addr_t];
    dcache_pkg::addr_t last_line = '0;   // line of the newest accepted request
    logic              q_op [$];
    logic              q_fast [$];   // answer due on the next cycle
    dcache_pkg::word_t q_data [$];
    int                q_cyc [$];

    dcache_top u_dcache_top (.*);

    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic dcache_pkg::word_t cpu_view(input dcache_pkg::addr_t a);
        return cpu_mem.exists(a) ? cpu_mem[a] : (a ^ 32'h5a5a_0000);
    endfunction

    function automatic dcache_pkg::word_t mem_word(input dcache_pkg::addr_t a);
        return mem_img.exists(a) ? mem_img[a] : (a ^ 32'h5a5a_0000);
    endfunction

    task automatic draw_random(input int n, output int r);
        rng = xorshift(rng);
        r = rng % n;
    endtask

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "simulation stopped");
    endtask

    task automatic compare_word(input string name, input dcache_pkg::word_t got,
                                input dcache_pkg::word_t exp);
        if (got !== exp) report_failure($sformatf("Error: %s got %h expected %h", name, got, exp));
    endtask

    task automatic compare_addr(input string name, input dcache_pkg::addr_t got,
                                input dcache_pkg::addr_t exp);
        if (got !== exp) report_failure($sformatf("Error: %s got %h expected %h", name, got, exp));
    endtask

    task automatic compare_line(input string name, input dcache_pkg::line_t got,
                                input dcache_pkg::line_t exp);
        if (got !== exp) report_failure($sformatf("Error: %s got %h expected %h", name, got, exp));
    endtask

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (limit > 0 && cyc > limit) report_failure("timeout, the cache stopped answering");
    end

    // responses come back in order
    always @(negedge clk) begin
        if (!reset && data_ok) begin
            if (q_op.size() == 0) report_failure("data_ok came with no request outstanding");
            if (q_fast[0] && cyc != q_cyc[0] + 1)
                report_failure($sformatf("data_ok for a hit came %0d cycles late",
                                         cyc - q_cyc[0] - 1));
            if (!q_op[0]) compare_word("rdata", rdata, q_data[0]);
            void'(q_op.pop_front());
            void'(q_fast.pop_front());
            void'(q_data.pop_front());
            void'(q_cyc.pop_front());
            done_count++;
        end
    end

    initial begin : memory_model
        dcache_pkg::addr_t base;
        dcache_pkg::line_t exp_line;
        int                d;
        forever begin
            @(negedge clk);
            if (wr_req) begin
                draw_random(4, d);
                repeat (d) @(posedge clk);
                @(posedge clk);
                #2 wr_rdy = 1'b1;
                @(negedge clk);
                if (!wr_req) report_failure("wr_req dropped before wr_rdy");
                base = wr_addr;
                // the victim shares the set of the missing request
                compare_addr("wr_addr", base, {base[31:12], last_line[11:0]});
                if (!dirty_lines.exists(base))
                    report_failure($sformatf("write-back of line %h which holds no store", base));
                for (int k = 0; k < 4; k++) exp_line[k*32 +: 32] = cpu_view(base + 4 * k);
                compare_line("wr_data", wr_data, exp_line);
                for (int k = 0; k < 4; k++) mem_img[base + 4 * k] = wr_data[k*32 +: 32];
                dirty_lines.delete(base);
                @(posedge clk);
                #2 wr_rdy = 1'b0;
            end else if (rd_req) begin
                base = rd_addr;
                compare_addr("rd_addr", base, last_line);
                draw_random(4, d);
                repeat (d) @(posedge clk);
                @(posedge clk);
                #2 rd_rdy = 1'b1;
                @(posedge clk);
                #2 rd_rdy = 1'b0;
                for (int k = 0; k < 4; k++) begin
                    draw_random(2, d);
                    repeat (d) begin
                        @(posedge clk);
                        #2;
                    end
                    ret_valid = 1'b1;
                    ret_data  = mem_word(base + 4 * k);
                    ret_last  = (k == 3);
                    @(posedge clk);
                    #2 ret_valid = 1'b0;
                    ret_last = 1'b0;
                end
            end
        end
    end

    initial begin : driver
        logic [3:0]            op_f;
        dcache_pkg::addr_t     a, line, prev_line;
        dcache_pkg::wstrb_t    st;
        dcache_pkg::word_t     wd, ex, pred;
        logic                  have_prev;
        logic                  prev_op;
        dcache_pkg::bank_sel_t prev_bank;
        int                    prev_cyc;
        logic                  accepted;
        reset = 1'b1;
        valid = 1'b0;
        req = '0;
        rd_rdy = 1'b0;
        ret_valid = 1'b0;
        ret_last = 1'b0;
        ret_data = '0;
        wr_rdy = 1'b0;
        have_prev = 1'b0;
        prev_line = '0;
        prev_op = 1'b0;
        prev_bank = '0;
        prev_cyc = 0;
        $readmemh("tb/dcache_patterns.hex", patterns);
        while (npat < MAX_PATTERNS && patterns[npat][103:100] != 4'hf) npat++;
        if (npat == 0) report_failure("no patterns were read from the pattern file");
        limit = 40 * npat + 100;
        repeat (2) @(posedge clk);
        #2 reset = 1'b0;
        for (int i = 0; i < npat; i++) begin
            {op_f, a, st, wd, ex} = patterns[i];
            line = {a[31:4], 4'h0};
            pred = cpu_view({a[31:2], 2'b00});
            if (!op_f[0]) compare_word("pattern expected data", ex, pred);
            valid     = 1'b1;
            req.op    = op_f[0];
            req.tag   = a[31:12];
            req.index = a[11:4];
            req.offset = a[3:0];
            req.wstrb = st;
            req.wdata = wd;
            accepted  = 1'b0;
            while (!accepted) begin
                @(negedge clk);
                if (addr_ok) begin
                    accepted = 1'b1;
                end else begin
                    @(posedge clk);
                    #2;
                end
            end
            // a load right behind a store to the same bank has to wait
            if (!op_f[0] && have_prev && prev_op && prev_bank == a[3:2] &&
                cyc == prev_cyc + 1) begin
                report_failure("addr_ok let a load follow a store to its bank back to back");
            end
            q_op.push_back(op_f[0]);
            q_fast.push_back(op_f[0] || (have_prev && prev_line == line));
            q_data.push_back(pred);
            q_cyc.push_back(cyc);
            last_line = line;
            if (op_f[0]) begin
                for (int b = 0; b < 4; b++) if (st[b]) pred[b*8 +: 8] = wd[b*8 +: 8];
                cpu_mem[{a[31:2], 2'b00}] = pred;
                dirty_lines[line] = 1'b1;
            end
            prev_line = line;
            prev_op   = op_f[0];
            prev_bank = a[3:2];
            prev_cyc  = cyc;
            have_prev = 1'b1;
            @(posedge clk);
            #2;
        end
        valid = 1'b0;
        req = '0;
        while (done_count < npat) @(negedge clk);
        $display("** PASS **");
        $finish;
    end

endmodule

//--- tb/dcache_patterns.hex
// op (0 load, 1 store, f end), byte address, wstrb, wdata, expected load data
// wstrb and wdata are zero for loads, expected data is zero for stores
0_00000100_0_00000000_5a5a0100
0_00000104_0_00000000_5a5a0104
0_0000010c_0_00000000_5a5a010c
1_00000104_3_aaaabbbb_00000000
0_00000104_0_00000000_5a5abbbb
1_00001108_c_12340000_00000000
0_00001108_0_00000000_12341108
1_00001100_f_deadbeef_00000000
0_00001100_0_00000000_deadbeef
0_00002100_0_00000000_5a5a2100
0_00000104_0_00000000_5a5abbbb
0_00001108_0_00000000_12341108
0_00002104_0_00000000_5a5a2104
0_00001100_0_00000000_deadbeef
0_00000200_0_00000000_5a5a0200
1_00000204_f_01010101_00000000
1_00000204_1_000000ff_00000000
0_00000204_0_00000000_010101ff
1_00000208_2_0000ab00_00000000
0_00000208_0_00000000_5a5aab08
0_00000204_0_00000000_010101ff
1_0000020c_f_cafef00d_00000000
0_0000020c_0_00000000_cafef00d
0_00003204_0_00000000_5a5a3204
0_00004208_0_00000000_5a5a4208
0_00000204_0_00000000_010101ff
0_0000020c_0_00000000_cafef00d
0_00001104_0_00000000_5a5a1104
0_00000210_0_00000000_5a5a0210
f_00000000_0_00000000_00000000

//--- vlog.f
common/dcache_pkg.sv
cache_arrays/sram_bank.sv
cache_arrays/cache_arrays.sv
src/store_buffer.sv
cache_ctrl/cache_ctrl.sv
src/dcache_top.sv
tb/dcache_checker.sv
tb/tb_dcache.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_dcache -f vlog.f -o sim_dcache
./obj_dir/sim_dcache | tee sim.log

if grep -q '\*\* PASS \*\*' sim.log; then
    exit 0
else
    exit 1
fi
